/* logic/adc_capture_pkg.sv */
package adc_capture_pkg;

  // Lane counts
  localparam int NUM_LANES  = 4;
  // Data lanes plus the frame lane, frame lane is the top index
  localparam int NUM_DELAYS = NUM_LANES + 1;

  // Delay tap range, 0 to 31 extra cycles
  localparam int TAP_W       = 5;
  localparam int TAP_DEFAULT = 4;
  localparam int HIST_DEPTH  = 2 ** TAP_W;

  // ADC word format, MSB first
  localparam int WORD_W     = 10;
  localparam int WORD_CNT_W = $clog2(WORD_W);

  // Cycles with tracking off before the new tap is presented
  localparam int SETTLE_CYCLES = 12;
  localparam int SETTLE_CNT_W  = $clog2(SETTLE_CYCLES + 1);

  // Register map, byte addresses
  localparam logic [31:0] REG_TAP_VALUE = 32'h0000_0000;
  localparam logic [31:0] REG_LANE_MASK = 32'h0000_0004;
  localparam logic [31:0] REG_CONTROL   = 32'h0000_0008;
  localparam logic [31:0] REG_STATUS    = 32'h0000_000C;

  // Bit positions inside the control and status words
  localparam int CTRL_GO_BIT   = 0;
  localparam int STAT_BUSY_BIT = 0;

  // Update sequencer states
  typedef enum logic [2:0] {
    UPD_IDLE,
    UPD_VTC_OFF,
    UPD_SETTLE,
    UPD_SET_VALUE,
    UPD_LOAD,
    UPD_VTC_ON
  } upd_state_e;

endpackage

/* logic/wb_delay_regs.sv */
`timescale 1ns/1ns

module wb_delay_regs (
  input  logic                                     delay_clk,
  input  logic                                     rst,
  input  logic                                     wb_cyc_i,
  input  logic                                     wb_stb_i,
  input  logic                                     wb_we_i,
  input  logic [31:0]                              wb_adr_i,
  input  logic [3:0]                               wb_sel_i,
  input  logic [31:0]                              wb_dat_i,
  input  logic                                     busy_i,
  output logic [31:0]                              wb_dat_o,
  output logic                                     wb_ack_o,
  output logic                                     wb_err_o,
  output logic [adc_capture_pkg::TAP_W-1:0]        tap_value_o,
  output logic [adc_capture_pkg::NUM_DELAYS-1:0]   lane_mask_o,
  output logic                                     update_go_o
);

  import adc_capture_pkg::*;

  logic        req;
  logic        addr_hit;
  logic        wr_req;
  logic [31:0] rd_data;

  // One request per transfer, ignore stb while the answer is on the bus
  assign req    = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o;
  assign wr_req = req && wb_we_i && addr_hit;

  // Address decode and read mux
  always_comb begin
    addr_hit = 1'b1;
    rd_data  = 32'h0;
    case (wb_adr_i)
      REG_TAP_VALUE: rd_data[TAP_W-1:0] = tap_value_o;
      REG_LANE_MASK: rd_data[NUM_DELAYS-1:0] = lane_mask_o;
      REG_CONTROL:   rd_data = 32'h0;
      REG_STATUS:    rd_data[STAT_BUSY_BIT] = busy_i;
      default:       addr_hit = 1'b0;
    endcase
  end

  // Bus response, one registered cycle after the request
  always_ff @(posedge delay_clk) begin
    if (rst) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= req && addr_hit;
      wb_err_o <= req && !addr_hit;
    end
  end

  always_ff @(posedge delay_clk) begin
    if (req && !wb_we_i) begin
      wb_dat_o <= rd_data;
    end
  end

  // Tap value and lane mask, byte enabled
  always_ff @(posedge delay_clk) begin
    if (rst) begin
      tap_value_o <= TAP_W'(TAP_DEFAULT);
      lane_mask_o <= '0;
    end else if (wr_req) begin
      if (wb_adr_i == REG_TAP_VALUE) begin
        for (int i = 0; i < TAP_W; i++) begin
          if (wb_sel_i[i / 8]) begin
            tap_value_o[i] <= wb_dat_i[i];
          end
        end
      end
      if (wb_adr_i == REG_LANE_MASK) begin
        for (int i = 0; i < NUM_DELAYS; i++) begin
          if (wb_sel_i[i / 8]) begin
            lane_mask_o[i] <= wb_dat_i[i];
          end
        end
      end
    end
  end

  // Go pulse lines up with the write's ack
  always_ff @(posedge delay_clk) begin
    if (rst) begin
      update_go_o <= 1'b0;
    end else begin
      update_go_o <= wr_req && (wb_adr_i == REG_CONTROL) &&
                     wb_sel_i[0] && wb_dat_i[CTRL_GO_BIT];
    end
  end

endmodule

/* logic/delay_update_ctrl.sv */
`timescale 1ns/1ns

module delay_update_ctrl (
  input  logic                                   delay_clk,
  input  logic                                   rst,
  input  logic                                   update_go_i,
  input  logic [adc_capture_pkg::TAP_W-1:0]      tap_value_i,
  input  logic [adc_capture_pkg::NUM_DELAYS-1:0] lane_mask_i,
  output logic                                   busy_o,
  output logic [adc_capture_pkg::NUM_DELAYS-1:0] en_vtc_o,
  output logic [adc_capture_pkg::NUM_DELAYS-1:0] load_o,
  output logic [adc_capture_pkg::TAP_W-1:0]      tap_val_o
);

  import adc_capture_pkg::*;

  upd_state_e              state;
  upd_state_e              state_nxt;
  logic [SETTLE_CNT_W-1:0] settle_cnt;
  logic [TAP_W-1:0]        val_q;
  logic [NUM_DELAYS-1:0]   mask_q;
  logic                    vtc_off;

  // Next state
  always_comb begin
    state_nxt = state;
    case (state)
      UPD_IDLE: begin
        if (update_go_i) begin
          state_nxt = UPD_VTC_OFF;
        end
      end
      UPD_VTC_OFF:   state_nxt = UPD_SETTLE;
      UPD_SETTLE: begin
        if (settle_cnt == '0) begin
          state_nxt = UPD_SET_VALUE;
        end
      end
      UPD_SET_VALUE: state_nxt = UPD_LOAD;
      UPD_LOAD:      state_nxt = UPD_VTC_ON;
      UPD_VTC_ON:    state_nxt = UPD_IDLE;
      default:       state_nxt = UPD_IDLE;
    endcase
  end

  always_ff @(posedge delay_clk) begin
    if (rst) begin
      state <= UPD_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Settle counter, loaded on entry so SETTLE lasts SETTLE_CYCLES
  always_ff @(posedge delay_clk) begin
    if (rst) begin
      settle_cnt <= '0;
    end else if (state == UPD_VTC_OFF) begin
      settle_cnt <= SETTLE_CNT_W'(SETTLE_CYCLES - 1);
    end else if (state == UPD_SETTLE && settle_cnt != '0) begin
      settle_cnt <= settle_cnt - 1'b1;
    end
  end

  // Snapshot of value and mask, later bus writes do not disturb an update
  always_ff @(posedge delay_clk) begin
    if (state == UPD_IDLE && update_go_i) begin
      val_q  <= tap_value_i;
      mask_q <= lane_mask_i;
    end
  end

  // Tracking off from VTC_OFF through LOAD
  assign vtc_off = (state == UPD_VTC_OFF) || (state == UPD_SETTLE) ||
                   (state == UPD_SET_VALUE) || (state == UPD_LOAD);

  assign busy_o    = (state != UPD_IDLE);
  assign en_vtc_o  = vtc_off ? ~mask_q : {NUM_DELAYS{1'b1}};
  assign load_o    = (state == UPD_LOAD) ? mask_q : '0;
  assign tap_val_o = val_q;

endmodule

/* logic/tap_delay_line.sv */
`timescale 1ns/1ns

module tap_delay_line (
  input  logic                              delay_clk,
  input  logic                              rst,
  input  logic                              en_vtc_i,
  input  logic                              load_i,
  input  logic [adc_capture_pkg::TAP_W-1:0] tap_val_i,
  input  logic                              din_i,
  output logic                              dout_o
);

  import adc_capture_pkg::*;

  logic [HIST_DEPTH-1:0] hist;
  logic [TAP_W-1:0]      tap;

  // Bit history, hist[0] is the newest sample
  always_ff @(posedge delay_clk) begin
    hist <= {hist[HIST_DEPTH-2:0], din_i};
  end

  // Tap register
  // A load only lands while tracking is off, as in the real delay cell
  always_ff @(posedge delay_clk) begin
    if (rst) begin
      tap <= TAP_W'(TAP_DEFAULT);
    end else if (load_i && !en_vtc_i) begin
      tap <= tap_val_i;
    end
  end

  // Tap 0 still costs the one history register
  assign dout_o = hist[tap];

endmodule

/* logic/word_deserializer.sv */
`timescale 1ns/1ns

module word_deserializer (
  input  logic                                                    delay_clk,
  input  logic                                                    rst,
  input  logic                                                    frame_i,
  input  logic [adc_capture_pkg::NUM_LANES-1:0]                   lanes_i,
  output logic [adc_capture_pkg::NUM_LANES*adc_capture_pkg::WORD_W-1:0] words_o,
  output logic                                                    word_valid_o
);

  import adc_capture_pkg::*;

  logic                  frame_q;
  logic                  frame_rise;
  logic [WORD_CNT_W-1:0] bit_cnt;
  logic                  last_bit;
  logic [WORD_W-2:0]     lane_sr [NUM_LANES];

  // The bit seen with the frame edge is the word's MSB
  assign frame_rise = frame_i && !frame_q;
  assign last_bit   = !frame_rise && (bit_cnt == WORD_CNT_W'(WORD_W - 1));

  // Start high so the first cycle after reset never looks like an edge
  always_ff @(posedge delay_clk) begin
    if (rst) begin
      frame_q <= 1'b1;
    end else begin
      frame_q <= frame_i;
    end
  end

  // Bit counter, zero while waiting for an edge
  always_ff @(posedge delay_clk) begin
    if (rst) begin
      bit_cnt <= '0;
    end else if (frame_rise) begin
      bit_cnt <= WORD_CNT_W'(1);
    end else if (last_bit) begin
      bit_cnt <= '0;
    end else if (bit_cnt != '0) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

  // Per lane shift registers and word publish
  always_ff @(posedge delay_clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_sr[i] <= {lane_sr[i][WORD_W-3:0], lanes_i[i]};
      if (last_bit) begin
        words_o[i*WORD_W +: WORD_W] <= {lane_sr[i], lanes_i[i]};
      end
    end
  end

  always_ff @(posedge delay_clk) begin
    if (rst) begin
      word_valid_o <= 1'b0;
    end else begin
      word_valid_o <= last_bit;
    end
  end

endmodule

/* logic/adc_capture_top.sv */
`timescale 1ns/1ns

module adc_capture_top (
  input  logic                                                    delay_clk,
  input  logic                                                    rst,
  input  logic                                                    wb_cyc_i,
  input  logic                                                    wb_stb_i,
  input  logic                                                    wb_we_i,
  input  logic [31:0]                                             wb_adr_i,
  input  logic [3:0]                                              wb_sel_i,
  input  logic [31:0]                                             wb_dat_i,
  output logic [31:0]                                             wb_dat_o,
  output logic                                                    wb_ack_o,
  output logic                                                    wb_err_o,
  input  logic                                                    frame_i,
  input  logic [adc_capture_pkg::NUM_LANES-1:0]                   din_i,
  output logic [adc_capture_pkg::NUM_LANES*adc_capture_pkg::WORD_W-1:0] dout_o,
  output logic                                                    dout_valid_o
);

  import adc_capture_pkg::*;

  logic [TAP_W-1:0]      tap_value;
  logic [NUM_DELAYS-1:0] lane_mask;
  logic                  update_go;
  logic                  busy;
  logic [NUM_DELAYS-1:0] en_vtc;
  logic [NUM_DELAYS-1:0] load;
  logic [TAP_W-1:0]      tap_val;
  logic [NUM_DELAYS-1:0] dly_in;
  logic [NUM_DELAYS-1:0] dly_out;

  // Frame lane sits on the top delay index
  assign dly_in = {frame_i, din_i};

  wb_delay_regs u_wb_delay_regs (
    .delay_clk   (delay_clk),
    .rst         (rst),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_i    (wb_dat_i),
    .busy_i      (busy),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .wb_err_o    (wb_err_o),
    .tap_value_o (tap_value),
    .lane_mask_o (lane_mask),
    .update_go_o (update_go)
  );

  delay_update_ctrl u_delay_update_ctrl (
    .delay_clk   (delay_clk),
    .rst         (rst),
    .update_go_i (update_go),
    .tap_value_i (tap_value),
    .lane_mask_i (lane_mask),
    .busy_o      (busy),
    .en_vtc_o    (en_vtc),
    .load_o      (load),
    .tap_val_o   (tap_val)
  );

  for (genvar g = 0; g < NUM_DELAYS; g++) begin : g_delay
    tap_delay_line u_tap_delay_line (
      .delay_clk (delay_clk),
      .rst       (rst),
      .en_vtc_i  (en_vtc[g]),
      .load_i    (load[g]),
      .tap_val_i (tap_val),
      .din_i     (dly_in[g]),
      .dout_o    (dly_out[g])
    );
  end

  word_deserializer u_word_deserializer (
    .delay_clk    (delay_clk),
    .rst          (rst),
    .frame_i      (dly_out[NUM_DELAYS-1]),
    .lanes_i      (dly_out[NUM_LANES-1:0]),
    .words_o      (dout_o),
    .word_valid_o (dout_valid_o)
  );

endmodule

/* test/adc_capture_checker.sv */
`timescale 1ns/1ns

module adc_capture_checker (
  input logic                                   delay_clk,
  input logic                                   rst,
  input logic                                   busy_i,
  input logic [adc_capture_pkg::NUM_DELAYS-1:0] en_vtc_i,
  input logic [adc_capture_pkg::NUM_DELAYS-1:0] load_i,
  input logic                                   ack_i,
  input logic                                   err_i
);

  import adc_capture_pkg::*;

  // VTC_OFF, SETTLE, SET_VALUE, LOAD and VTC_ON
  localparam int BUSY_CYCLES = SETTLE_CYCLES + 4;

  // A load may only hit a lane with tracking off
  assert property (@(posedge delay_clk) disable iff (rst) (load_i & en_vtc_i) == '0)
    else $error("load pulsed on a lane with tracking enabled");

  assert property (@(posedge delay_clk) disable iff (rst) !(ack_i && err_i))
    else $error("Wishbone ack and err high in the same cycle");

  assert property (@(posedge delay_clk) disable iff (rst)
    $rose(busy_i) |-> busy_i [*BUSY_CYCLES] ##1 !busy_i)
    else $error("busy did not last exactly %0d cycles", BUSY_CYCLES);

endmodule

/* test/adc_capture_monitor.sv */
`timescale 1ns/1ns

module adc_capture_monitor (
  input  logic                                                    delay_clk,
  input  logic                                                    rst,
  input  logic                                                    frame_i,
  input  logic [adc_capture_pkg::NUM_LANES-1:0]                   din_i,
  input  logic [adc_capture_pkg::NUM_LANES*adc_capture_pkg::WORD_W-1:0] dout_i,
  input  logic                                                    dout_valid_i,
  output int                                                      error_cnt_o,
  output int                                                      word_cnt_o
);

  import adc_capture_pkg::*;

  localparam int FRAME_IDX = NUM_DELAYS - 1;

  logic                          check_en;
  string                         test_name;
  logic [HIST_DEPTH-1:0]         in_sr [NUM_DELAYS];
  int                            model_tap [NUM_DELAYS];
  logic                          frame_q;
  int                            bit_cnt;
  logic [WORD_W-1:0]             word_sr [NUM_LANES];
  logic                          exp_valid;
  logic [NUM_LANES*WORD_W-1:0]   exp_words;

  initial begin
    check_en    = 1'b0;
    test_name   = "startup";
    error_cnt_o = 0;
    word_cnt_o  = 0;
    frame_q     = 1'b1;
    bit_cnt     = 0;
    exp_valid   = 1'b0;
    exp_words   = '0;
    for (int i = 0; i < NUM_DELAYS; i++) begin
      in_sr[i]     = '0;
      model_tap[i] = TAP_DEFAULT;
    end
  end

  // Called by the testbench once an update has been applied
  task set_taps(input logic [NUM_DELAYS-1:0] mask, input int value);
    for (int i = 0; i < NUM_DELAYS; i++) begin
      if (mask[i]) begin
        model_tap[i] = value;
      end
    end
  endtask

  // Inputs seen here are the ones the DUT takes on the next rising edge
  always @(negedge delay_clk) begin
    logic [NUM_DELAYS-1:0] dly;
    logic                  rise;
    logic                  last;
    if (check_en) begin
      if (dout_valid_i !== exp_valid) begin
        error_cnt_o++;
        $display("ERROR %s valid: expected %b actual %b", test_name, exp_valid, dout_valid_i);
      end else if (exp_valid) begin
        word_cnt_o++;
        for (int l = 0; l < NUM_LANES; l++) begin
          if (dout_i[l*WORD_W +: WORD_W] !== exp_words[l*WORD_W +: WORD_W]) begin
            error_cnt_o++;
            $display("ERROR %s lane %0d: expected %h actual %h", test_name, l,
                     exp_words[l*WORD_W +: WORD_W], dout_i[l*WORD_W +: WORD_W]);
          end
        end
      end
    end
    // Each lane arrives tap plus one cycles late
    for (int i = 0; i < NUM_DELAYS; i++) begin
      dly[i] = in_sr[i][model_tap[i]];
    end
    if (rst) begin
      for (int i = 0; i < NUM_DELAYS; i++) begin
        model_tap[i] = TAP_DEFAULT;
      end
      frame_q   = 1'b1;
      bit_cnt   = 0;
      exp_valid = 1'b0;
    end else begin
      rise = dly[FRAME_IDX] && !frame_q;
      last = !rise && (bit_cnt == WORD_W - 1);
      for (int l = 0; l < NUM_LANES; l++) begin
        word_sr[l] = {word_sr[l][WORD_W-2:0], dly[l]};
        if (last) begin
          exp_words[l*WORD_W +: WORD_W] = word_sr[l];
        end
      end
      exp_valid = last;
      if (rise) begin
        bit_cnt = 1;
      end else if (last) begin
        bit_cnt = 0;
      end else if (bit_cnt != 0) begin
        bit_cnt++;
      end
      frame_q = dly[FRAME_IDX];
    end
    for (int i = 0; i < NUM_DELAYS; i++) begin
      in_sr[i] = {in_sr[i][HIST_DEPTH-2:0], (i == FRAME_IDX) ? frame_i : din_i[i]};
    end
  end

endmodule

/* test/adc_capture_tb.sv */
`timescale 1ns/1ns

module adc_capture_tb;

  import adc_capture_pkg::*;

  localparam int ACK_TIMEOUT = 20;
  localparam int POLL_LIMIT  = 30;
  localparam int VALID_TIMEOUT = 3 * WORD_W;

  logic                        delay_clk;
  logic                        rst;
  logic                        wb_cyc_i;
  logic                        wb_stb_i;
  logic                        wb_we_i;
  logic [31:0]                 wb_adr_i;
  logic [3:0]                  wb_sel_i;
  logic [31:0]                 wb_dat_i;
  logic [31:0]                 wb_dat_o;
  logic                        wb_ack_o;
  logic                        wb_err_o;
  logic                        frame_i;
  logic [NUM_LANES-1:0]        din_i;
  logic [NUM_LANES*WORD_W-1:0] dout_o;
  logic                        dout_valid_o;
  logic [15:0]                 lfsr;
  int                          frame_cnt;
  int                          tb_errors;
  int                          mon_errors;
  int                          word_cnt;

  adc_capture_top u_adc_capture_top (.*);

  adc_capture_monitor u_monitor (
    .delay_clk    (delay_clk),
    .rst          (rst),
    .frame_i      (frame_i),
    .din_i        (din_i),
    .dout_i       (dout_o),
    .dout_valid_i (dout_valid_o),
    .error_cnt_o  (mon_errors),
    .word_cnt_o   (word_cnt)
  );

  bind adc_capture_top adc_capture_checker u_checker (
    .delay_clk (delay_clk),
    .rst       (rst),
    .busy_i    (busy),
    .en_vtc_i  (en_vtc),
    .load_i    (load),
    .ack_i     (wb_ack_o),
    .err_i     (wb_err_o)
  );

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  initial begin
    delay_clk = 1'b0;
    forever #20 delay_clk = ~delay_clk;
  end

  // Serial data bits and a frame of five ones then five zeros
  always @(posedge delay_clk) begin : stimulus
    logic [NUM_LANES-1:0] bits;
    for (int i = 0; i < NUM_LANES; i++) begin
      lfsr    = lfsr_next(lfsr);
      bits[i] = lfsr[0];
    end
    din_i     <= bits;
    frame_i   <= (frame_cnt < 5);
    frame_cnt  = (frame_cnt + 1) % WORD_W;
  end

  task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat, output logic err);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    err  = 1'b0;
    rdat = '0;
    @(posedge delay_clk);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_sel_i <= 4'hF;
    wb_dat_i <= wdat;
    while (!done && n < ACK_TIMEOUT) begin
      @(negedge delay_clk);
      n++;
      if (wb_ack_o || wb_err_o) begin
        done = 1'b1;
        err  = wb_err_o;
        rdat = wb_dat_o;
      end
    end
    @(posedge delay_clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    if (!done) begin
      tb_errors++;
      $display("Wishbone access to %h got neither ack nor err in time", adr);
    end
  endtask

  task check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      tb_errors++;
      $display("ERROR %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task write_reg(input logic [31:0] adr, input logic [31:0] dat);
    logic [31:0] d;
    logic        e;
    wb_access(1'b1, adr, dat, d, e);
    if (e) begin
      tb_errors++;
      $display("Write to %h was answered with err", adr);
    end
  endtask

  task read_expect(input string name, input logic [31:0] adr, input logic [31:0] exp);
    logic [31:0] d;
    logic        e;
    wb_access(1'b0, adr, '0, d, e);
    if (e) begin
      tb_errors++;
      $display("%s: read of %h was answered with err", name, adr);
    end else begin
      check_value(name, exp, d);
    end
  endtask

  task expect_bus_err(input string name, input logic we, input logic [31:0] adr);
    logic [31:0] d;
    logic        e;
    wb_access(we, adr, 32'hFFFF_FFFF, d, e);
    if (!e) begin
      tb_errors++;
      $display("%s: access to unmapped %h was not answered with err", name, adr);
    end
  endtask

  task wait_idle(input string name);
    logic [31:0] d;
    logic        e;
    int          n;
    n = 0;
    do begin
      wb_access(1'b0, REG_STATUS, '0, d, e);
      n++;
    end while (d[STAT_BUSY_BIT] && n < POLL_LIMIT);
    if (d[STAT_BUSY_BIT]) begin
      tb_errors++;
      $display("%s: busy did not clear before the timeout", name);
    end
  endtask

  // Returns on the falling edge that shows a word valid pulse
  task wait_valid(input string name);
    int n;
    n = 0;
    @(negedge delay_clk);
    while (dout_valid_o !== 1'b1 && n < VALID_TIMEOUT) begin
      @(negedge delay_clk);
      n++;
    end
    if (dout_valid_o !== 1'b1) begin
      tb_errors++;
      $display("%s: no output word arrived before the timeout", name);
    end
  endtask

  task run_checked(input string name, input int cycles);
    u_monitor.test_name = name;
    u_monitor.check_en  = 1'b1;
    repeat (cycles) @(posedge delay_clk);
  endtask

  initial begin
    rst       = 1'b1;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_adr_i  = '0;
    wb_sel_i  = '0;
    wb_dat_i  = '0;
    frame_i   = 1'b0;
    din_i     = '0;
    lfsr      = 16'd83;
    frame_cnt = 0;
    tb_errors = 0;
    repeat (2) @(posedge delay_clk);
    rst <= 1'b0;

    // History lines fill before words are compared
    repeat (60) @(posedge delay_clk);
    run_checked("default_alignment", 120);

    write_reg(REG_TAP_VALUE, 32'd7);
    read_expect("tap_readback", REG_TAP_VALUE, 32'd7);
    write_reg(REG_LANE_MASK, 32'h0A);
    read_expect("mask_readback", REG_LANE_MASK, 32'h0A);
    expect_bus_err("unmapped_write", 1'b1, 32'h10);
    expect_bus_err("unmapped_read", 1'b0, 32'h14);
    read_expect("tap_unchanged", REG_TAP_VALUE, 32'd7);
    read_expect("mask_unchanged", REG_LANE_MASK, 32'h0A);

    // Skew every data lane and try a second go while busy
    u_monitor.check_en = 1'b0;
    write_reg(REG_TAP_VALUE, 32'd9);
    write_reg(REG_LANE_MASK, 32'h0F);
    write_reg(REG_CONTROL, 32'h1);
    read_expect("status_busy", REG_STATUS, 32'h1);
    write_reg(REG_TAP_VALUE, 32'd2);
    write_reg(REG_CONTROL, 32'h1);
    wait_idle("update_sequence");
    read_expect("status_stays_idle", REG_STATUS, 32'h0);
    u_monitor.set_taps(5'h0F, 9);
    repeat (60) @(posedge delay_clk);
    run_checked("skewed_taps", 150);

    // Reset lands on the edge that would publish the next word
    u_monitor.check_en = 1'b0;
    wait_valid("reset_mid_stream");
    repeat (WORD_W - 1) @(posedge delay_clk);
    rst <= 1'b1;
    @(posedge delay_clk);
    rst <= 1'b0;
    @(negedge delay_clk);
    check_value("reset_valid", 32'h0, {31'h0, dout_valid_o});
    read_expect("reset_tap_reg", REG_TAP_VALUE, TAP_DEFAULT);
    repeat (60) @(posedge delay_clk);
    run_checked("after_reset", 120);

    if (word_cnt == 0) begin
      tb_errors++;
      $display("No output words were compared");
    end
    $display("bus errors %0d, word errors %0d, words checked %0d",
             tb_errors, mon_errors, word_cnt);
    if (tb_errors == 0 && mon_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* src.f */
logic/adc_capture_pkg.sv
logic/wb_delay_regs.sv
logic/delay_update_ctrl.sv
logic/tap_delay_line.sv
logic/word_deserializer.sv
logic/adc_capture_top.sv
test/adc_capture_checker.sv
test/adc_capture_monitor.sv
test/adc_capture_tb.sv
